// File: hw/load_packer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte and halfword select with sign or zero extension for loads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module load_packer (
  input  mem_node_pkg::data_t      mem_data_i,
  input  mem_node_pkg::load_info_s load_info_i,
  output mem_node_pkg::data_t      load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        byte_fill;
  logic        half_fill;

  assign byte_sel = mem_data_i[{load_info_i.part_sel, 3'b000} +: 8];
  assign half_sel = load_info_i.part_sel[1] ? mem_data_i[31:16] : mem_data_i[15:0];

  // Fill bit is the MSB of the selection unless the load is unsigned.
  assign byte_fill = ~load_info_i.is_unsigned & byte_sel[7];
  assign half_fill = ~load_info_i.is_unsigned & half_sel[15];

  always_comb begin
    if (load_info_i.is_byte) begin
      load_data_o = {{(mem_node_pkg::data_width-8){byte_fill}}, byte_sel};
    end else if (load_info_i.is_hex) begin
      load_data_o = {{(mem_node_pkg::data_width-16){half_fill}}, half_sel};
    end else begin
      load_data_o = mem_data_i;
    end
  end

endmodule

// File: hw/mem_array_1rw.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous memory with byte write mask.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_array_1rw (
  input  logic                    clk_i,
  input  logic                    v_i,
  input  logic                    w_i,
  input  mem_node_pkg::mem_addr_t addr_i,
  input  mem_node_pkg::data_t     data_i,
  input  mem_node_pkg::mask_t     mask_i,
  output mem_node_pkg::data_t     data_o
);

  mem_node_pkg::data_t mem_r [mem_node_pkg::mem_els] = '{default: '0};
  mem_node_pkg::data_t wr_word;

  // Merge the masked bytes into the current word.
  always_comb begin
    wr_word = mem_r[addr_i];
    for (int b = 0; b < mem_node_pkg::mask_width; b++) begin
      if (mask_i[b]) begin
        wr_word[8*b +: 8] = data_i[8*b +: 8];
      end
    end
  end

  // Write-first. data_o keeps its value when there is no access.
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_r[addr_i] <= wr_word;
        data_o        <= wr_word;
      end else begin
        data_o        <= mem_r[addr_i];
      end
    end
  end

endmodule

// File: hw/mem_node_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and packet formats for the memory node.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_node_pkg;

  localparam int data_width     = 32;
  localparam int mask_width     = 4;
  localparam int mem_els        = 1024;
  localparam int mem_addr_width = 10;
  localparam int addr_width     = 12;
  localparam int fifo_els       = 4;
  localparam int x_cord_width   = 4;
  localparam int y_cord_width   = 3;
  localparam int reg_id_width   = 5;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [mask_width-1:0]     mask_t;
  typedef logic [mem_addr_width-1:0] mem_addr_t;
  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [reg_id_width-1:0]   reg_id_t;
  typedef logic [x_cord_width-1:0]   x_cord_t;
  typedef logic [y_cord_width-1:0]   y_cord_t;

  // Store is byte masked, sw always writes the full word.
  typedef enum logic [2:0] {
    e_op_load,
    e_op_store,
    e_op_sw,
    e_op_amoswap,
    e_op_amoor,
    e_op_cache
  } op_e;

  typedef enum logic [1:0] {
    e_ret_credit,
    e_ret_int_wb,
    e_ret_float_wb,
    e_ret_ifetch
  } ret_type_e;

  typedef struct packed {
    logic       is_unsigned;
    logic       is_byte;
    logic       is_hex;
    logic [1:0] part_sel;
    logic       float_wb;
    logic       ifetch;
  } load_info_s;

  typedef struct packed {
    op_e        op;
    addr_t      addr;
    data_t      payload;
    mask_t      mask;
    reg_id_t    reg_id;
    x_cord_t    src_x;
    y_cord_t    src_y;
    load_info_s load_info;
  } req_pkt_s;

  typedef struct packed {
    ret_type_e pkt_type;
    data_t     data;
    reg_id_t   reg_id;
    x_cord_t   x_cord;
    y_cord_t   y_cord;
  } ret_pkt_s;

endpackage

// File: hw/mem_node_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory node top. Request queue, memory, load packer and responder.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_node_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_v_i,
  input  mem_node_pkg::req_pkt_s req_pkt_i,
  output logic                   req_ready_o,
  output logic                   ret_v_o,
  output mem_node_pkg::ret_pkt_s ret_pkt_o,
  input  logic                   ret_ready_i
);

  logic                     pkt_v, pkt_yumi;
  mem_node_pkg::req_pkt_s   pkt;
  logic                     mem_v, mem_w;
  mem_node_pkg::mem_addr_t  mem_addr;
  mem_node_pkg::data_t      mem_wdata, mem_rdata, load_data;
  mem_node_pkg::mask_t      mem_mask;
  mem_node_pkg::load_info_s load_info;

  req_fifo u_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_v_i),
    .pkt_i   (req_pkt_i),
    .ready_o (req_ready_o),
    .v_o     (pkt_v),
    .pkt_o   (pkt),
    .yumi_i  (pkt_yumi)
  );

  mem_array_1rw u_mem (
    .clk_i  (clk_i),
    .v_i    (mem_v),
    .w_i    (mem_w),
    .addr_i (mem_addr),
    .data_i (mem_wdata),
    .mask_i (mem_mask),
    .data_o (mem_rdata)
  );

  load_packer u_load_packer (
    .mem_data_i  (mem_rdata),
    .load_info_i (load_info),
    .load_data_o (load_data)
  );

  mem_responder u_responder (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pkt_v_i     (pkt_v),
    .pkt_i       (pkt),
    .pkt_yumi_o  (pkt_yumi),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_data_o  (mem_wdata),
    .mem_mask_o  (mem_mask),
    .mem_data_i  (mem_rdata),
    .load_data_i (load_data),
    .load_info_o (load_info),
    .ret_v_o     (ret_v_o),
    .ret_pkt_o   (ret_pkt_o),
    .ret_ready_i (ret_ready_i)
  );

endmodule

// File: hw/mem_responder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Responder FSM. Serves queued requests against the memory array
// and builds one return packet per request, in order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_responder (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     pkt_v_i,
  input  mem_node_pkg::req_pkt_s   pkt_i,
  output logic                     pkt_yumi_o,
  output logic                     mem_v_o,
  output logic                     mem_w_o,
  output mem_node_pkg::mem_addr_t  mem_addr_o,
  output mem_node_pkg::data_t      mem_data_o,
  output mem_node_pkg::mask_t      mem_mask_o,
  input  mem_node_pkg::data_t      mem_data_i,
  input  mem_node_pkg::data_t      load_data_i,
  output mem_node_pkg::load_info_s load_info_o,
  output logic                     ret_v_o,
  output mem_node_pkg::ret_pkt_s   ret_pkt_o,
  input  logic                     ret_ready_i
);

  typedef enum logic {
    e_ready,
    e_atomic
  } state_e;

  state_e                 state_r, state_n;
  mem_node_pkg::req_pkt_s req_r, req_n;
  logic                   ret_pend_r, ret_pend_n;
  logic                   take;
  logic                   is_amo;
  logic                   in_write;
  logic                   held_write;

  assign is_amo     = pkt_i.op inside {mem_node_pkg::e_op_amoswap, mem_node_pkg::e_op_amoor};
  assign in_write   = pkt_i.op inside {mem_node_pkg::e_op_store, mem_node_pkg::e_op_sw};
  assign held_write = req_r.op inside {mem_node_pkg::e_op_store, mem_node_pkg::e_op_sw};
  assign load_info_o = req_r.load_info;

  // Head is taken only when the return slot is free or draining now.
  assign take = (state_r == e_ready) & pkt_v_i & (~ret_pend_r | ret_ready_i);

  always_comb begin
    state_n    = state_r;
    req_n      = req_r;
    ret_pend_n = ret_pend_r;

    pkt_yumi_o = 1'b0;
    mem_v_o    = 1'b0;
    mem_w_o    = 1'b0;
    mem_addr_o = pkt_i.addr[mem_node_pkg::mem_addr_width-1:0];
    mem_data_o = pkt_i.payload;
    mem_mask_o = '1;

    ret_v_o          = 1'b0;
    ret_pkt_o        = '0;
    ret_pkt_o.x_cord = req_r.src_x;
    ret_pkt_o.y_cord = req_r.src_y;

    case (state_r)
      e_ready: begin
        pkt_yumi_o = take;
        mem_v_o    = take;
        mem_w_o    = in_write;
        if (pkt_i.op == mem_node_pkg::e_op_store) begin
          mem_mask_o = pkt_i.mask;
        end

        ret_v_o = ret_pend_r;
        if (held_write) begin
          ret_pkt_o.pkt_type = mem_node_pkg::e_ret_credit;
          ret_pkt_o.reg_id   = (req_r.op == mem_node_pkg::e_op_sw) ? req_r.reg_id : '0;
        end else begin
          if (req_r.load_info.ifetch) begin
            ret_pkt_o.pkt_type = mem_node_pkg::e_ret_ifetch;
          end else if (req_r.load_info.float_wb) begin
            ret_pkt_o.pkt_type = mem_node_pkg::e_ret_float_wb;
          end else begin
            ret_pkt_o.pkt_type = mem_node_pkg::e_ret_int_wb;
          end
          ret_pkt_o.data   = load_data_i;
          ret_pkt_o.reg_id = req_r.reg_id;
        end

        if (take) begin
          req_n      = pkt_i;
          ret_pend_n = ~is_amo;
          if (is_amo) begin
            state_n = e_atomic;
          end
        end else if (ret_ready_i) begin
          ret_pend_n = 1'b0;
        end
      end

      e_atomic: begin
        // Old word sits on mem_data_i until the write goes out.
        mem_v_o    = ret_ready_i;
        mem_w_o    = ret_ready_i;
        mem_addr_o = req_r.addr[mem_node_pkg::mem_addr_width-1:0];
        mem_data_o = (req_r.op == mem_node_pkg::e_op_amoor) ? (req_r.payload | mem_data_i)
                                                            : req_r.payload;

        ret_v_o            = 1'b1;
        ret_pkt_o.pkt_type = req_r.load_info.float_wb ? mem_node_pkg::e_ret_float_wb
                                                      : mem_node_pkg::e_ret_int_wb;
        ret_pkt_o.data     = mem_data_i;
        ret_pkt_o.reg_id   = req_r.reg_id;

        if (ret_ready_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_ready;
      ret_pend_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      ret_pend_r <= ret_pend_n;
    end
  end

  always_ff @(posedge clk_i) begin
    req_r <= req_n;
  end

  a_no_cache_op: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i |-> pkt_i.op != mem_node_pkg::e_op_cache)
    else $error("cache management op is not supported by this node");

  a_ret_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    ret_v_o && !ret_ready_i |=> ret_v_o && $stable(ret_pkt_o))
    else $error("return packet changed while stalled");

endmodule

// File: hw/req_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request queue in front of the responder.
// Valid/ready on the way in, valid/yumi on the way out.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module req_fifo (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   v_i,
  input  mem_node_pkg::req_pkt_s pkt_i,
  output logic                   ready_o,
  output logic                   v_o,
  output mem_node_pkg::req_pkt_s pkt_o,
  input  logic                   yumi_i
);

  mem_node_pkg::req_pkt_s buf_r [mem_node_pkg::fifo_els];
  logic [$clog2(mem_node_pkg::fifo_els)-1:0]   wr_ptr_r, rd_ptr_r;
  logic [$clog2(mem_node_pkg::fifo_els+1)-1:0] count_r;
  logic enq, deq;

  assign ready_o = (count_r != mem_node_pkg::fifo_els);
  assign v_o     = (count_r != '0);
  assign pkt_o   = buf_r[rd_ptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == mem_node_pkg::fifo_els - 1) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == mem_node_pkg::fifo_els - 1) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      buf_r[wr_ptr_r] <= pkt_i;
    end
  end

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("yumi asserted on an empty request queue");

endmodule

// File: run.sh
#!/bin/sh
# Build the memory node testbench with Verilator and run it.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module mem_node_tb -o mem_node_sim
./obj_dir/mem_node_sim

// File: src.f
hw/mem_node_pkg.sv
hw/req_fifo.sv
hw/mem_array_1rw.sv
hw/load_packer.sv
hw/mem_responder.sv
hw/mem_node_top.sv
verif/mem_node_tb.sv

// File: verif/mem_node_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory node. Table-driven requests, in-order
// return checking under random return back-pressure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_node_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam mem_node_pkg::op_e op_ld   = mem_node_pkg::e_op_load;
  localparam mem_node_pkg::op_e op_st   = mem_node_pkg::e_op_store;
  localparam mem_node_pkg::op_e op_sw   = mem_node_pkg::e_op_sw;
  localparam mem_node_pkg::op_e op_swap = mem_node_pkg::e_op_amoswap;
  localparam mem_node_pkg::op_e op_or   = mem_node_pkg::e_op_amoor;
  localparam mem_node_pkg::ret_type_e rt_cr  = mem_node_pkg::e_ret_credit;
  localparam mem_node_pkg::ret_type_e rt_int = mem_node_pkg::e_ret_int_wb;
  localparam mem_node_pkg::ret_type_e rt_flt = mem_node_pkg::e_ret_float_wb;
  localparam mem_node_pkg::ret_type_e rt_if  = mem_node_pkg::e_ret_ifetch;

  logic                   clk_i;
  logic                   reset_i;
  logic                   req_v_i;
  mem_node_pkg::req_pkt_s req_pkt_i;
  logic                   req_ready_o;
  logic                   ret_v_o;
  mem_node_pkg::ret_pkt_s ret_pkt_o;
  logic                   ret_ready_i;

  mem_node_pkg::req_pkt_s req_q[$];
  mem_node_pkg::ret_pkt_s exp_q[$];
  int                     n_entries = 0;
  int                     n_ret = 0;
  logic [31:0]            lfsr_r;

  mem_node_top DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_pkt_i   (req_pkt_i),
    .req_ready_o (req_ready_o),
    .ret_v_o     (ret_v_o),
    .ret_pkt_o   (ret_pkt_o),
    .ret_ready_i (ret_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_rand_bit(output logic b);
    b      = lfsr_r[0];
    lfsr_r = lfsr_next(lfsr_r);
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0.1f ns: %s got %h expected %h",
                         $realtime, name, got, exp));
    end
  endtask

  // Source coordinates come from the entry index and must come back unchanged.
  task automatic add_entry(input mem_node_pkg::op_e op, input mem_node_pkg::addr_t addr,
      input mem_node_pkg::data_t payload, input mem_node_pkg::mask_t mask,
      input mem_node_pkg::reg_id_t reg_id, input mem_node_pkg::load_info_s info,
      input mem_node_pkg::ret_type_e exp_type, input mem_node_pkg::data_t exp_data,
      input mem_node_pkg::reg_id_t exp_reg);
    mem_node_pkg::req_pkt_s req;
    mem_node_pkg::ret_pkt_s ret;
    int idx;
    idx           = req_q.size();
    req.op        = op;
    req.addr      = addr;
    req.payload   = payload;
    req.mask      = mask;
    req.reg_id    = reg_id;
    req.src_x     = idx[3:0];
    req.src_y     = idx[2:0] ^ 3'b101;
    req.load_info = info;
    ret.pkt_type  = exp_type;
    ret.data      = exp_data;
    ret.reg_id    = exp_reg;
    ret.x_cord    = req.src_x;
    ret.y_cord    = req.src_y;
    req_q.push_back(req);
    exp_q.push_back(ret);
  endtask

  task automatic send_request(input mem_node_pkg::req_pkt_s pkt);
    req_v_i   = 1'b1;
    req_pkt_i = pkt;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic build_table();
    // Load info bits: unsigned, byte, hex, part_sel(2), float_wb, ifetch.
    add_entry(op_sw,   12'h010, 32'h8badf00d, 4'h0, 5'd3,  7'b0_0_0_00_0_0, rt_cr,  32'h0, 5'd3);
    add_entry(op_ld,   12'h010, 32'h0,        4'h0, 5'd7,  7'b0_0_0_00_0_0, rt_int,
              32'h8badf00d, 5'd7);
    add_entry(op_sw,   12'h020, 32'ha1b2c3d4, 4'h0, 5'd1,  7'b0_0_0_00_0_0, rt_cr,  32'h0, 5'd1);
    // Masked store touches bytes 0 and 2 only, reg_id comes back zero.
    add_entry(op_st,   12'h020, 32'h55667788, 4'b0101, 5'd9, 7'b0_0_0_00_0_0, rt_cr, 32'h0, 5'd0);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd2,  7'b0_0_0_00_0_0, rt_int, 32'ha166c388, 5'd2);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd10, 7'b0_1_0_00_0_0, rt_int, 32'hffffff88, 5'd10);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd11, 7'b1_1_0_01_0_0, rt_int, 32'h000000c3, 5'd11);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd12, 7'b0_1_0_10_0_0, rt_int, 32'h00000066, 5'd12);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd13, 7'b0_1_0_11_0_0, rt_int, 32'hffffffa1, 5'd13);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd14, 7'b1_1_0_11_0_0, rt_int, 32'h000000a1, 5'd14);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd15, 7'b0_0_1_00_0_0, rt_int, 32'hffffc388, 5'd15);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd16, 7'b1_0_1_00_0_0, rt_int, 32'h0000c388, 5'd16);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd17, 7'b0_0_1_10_0_0, rt_int, 32'hffffa166, 5'd17);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd18, 7'b1_0_1_11_0_0, rt_int, 32'h0000a166, 5'd18);
    // Return type priority is ifetch, then float_wb, then int_wb.
    add_entry(op_ld,   12'h010, 32'h0, 4'h0, 5'd19, 7'b0_0_0_00_1_0, rt_flt, 32'h8badf00d, 5'd19);
    add_entry(op_ld,   12'h010, 32'h0, 4'h0, 5'd20, 7'b0_0_0_00_1_1, rt_if,  32'h8badf00d, 5'd20);
    add_entry(op_ld,   12'h010, 32'h0, 4'h0, 5'd21, 7'b0_0_0_00_0_1, rt_if,  32'h8badf00d, 5'd21);
    add_entry(op_swap, 12'h010, 32'h12345678, 4'h0, 5'd4, 7'b0_0_0_00_0_0, rt_int,
              32'h8badf00d, 5'd4);
    add_entry(op_ld,   12'h010, 32'h0, 4'h0, 5'd22, 7'b0_0_0_00_0_0, rt_int, 32'h12345678, 5'd22);
    add_entry(op_or,   12'h020, 32'h0f0f0000, 4'h0, 5'd6, 7'b0_0_0_00_1_0, rt_flt,
              32'ha166c388, 5'd6);
    add_entry(op_ld,   12'h020, 32'h0, 4'h0, 5'd23, 7'b0_0_0_00_0_0, rt_int, 32'haf6fc388, 5'd23);
    // Upper address bits are dropped, so 0xc05 and 0x005 are the same word.
    add_entry(op_sw,   12'hc05, 32'hcafebabe, 4'h0, 5'd0, 7'b0_0_0_00_0_0, rt_cr, 32'h0, 5'd0);
    add_entry(op_ld,   12'h005, 32'h0, 4'h0, 5'd24, 7'b0_0_0_00_0_0, rt_int, 32'hcafebabe, 5'd24);
  endtask

  initial begin
    reset_i   = 1'b1;
    req_v_i   = 1'b0;
    req_pkt_i = '0;
    build_table();
    n_entries = req_q.size();
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // Queue is empty and no return is pending out of reset.
    check_value("req_ready_o", 32'(req_ready_o), 32'd1);
    check_value("ret_v_o", 32'(ret_v_o), 32'd0);
    for (int i = 0; i < n_entries; i++) begin
      send_request(req_q[i]);
    end
    req_v_i   = 1'b0;
    req_pkt_i = '0;
    wait (n_ret == n_entries);
    // A few idle cycles to catch any extra return.
    repeat (10) @(posedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Return back-pressure, high about three cycles in four.
  initial begin
    logic b0;
    logic b1;
    ret_ready_i = 1'b0;
    lfsr_r      = 32'he3ac;
    forever begin
      @(posedge clk_i);
      #1;
      take_rand_bit(b0);
      take_rand_bit(b1);
      ret_ready_i = reset_i ? 1'b0 : (b0 | b1);
    end
  end

  // Sampled mid-cycle, the transfer happens on the next rising edge.
  initial begin
    mem_node_pkg::ret_pkt_s exp_pkt;
    forever begin
      @(negedge clk_i);
      if (!reset_i && ret_v_o && ret_ready_i) begin
        if (exp_q.size() == 0) begin
          fail_run("Return packet arrived with no request left to answer");
        end else begin
          exp_pkt = exp_q.pop_front();
          check_value("ret_pkt_o.pkt_type", 32'(ret_pkt_o.pkt_type), 32'(exp_pkt.pkt_type));
          check_value("ret_pkt_o.data", ret_pkt_o.data, exp_pkt.data);
          check_value("ret_pkt_o.reg_id", 32'(ret_pkt_o.reg_id), 32'(exp_pkt.reg_id));
          check_value("ret_pkt_o.x_cord", 32'(ret_pkt_o.x_cord), 32'(exp_pkt.x_cord));
          check_value("ret_pkt_o.y_cord", 32'(ret_pkt_o.y_cord), 32'(exp_pkt.y_cord));
          n_ret++;
        end
      end
    end
  end

  initial begin
    wait (n_entries > 0);
    repeat (200 * n_entries) @(posedge clk_i);
    fail_run($sformatf("Timeout: only %0d of %0d returns arrived", n_ret, n_entries));
  end

endmodule
